//--- hdl/idu_pkg.sv
`default_nettype none

package idu_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // rv32i major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_NORM = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // low bit of each instruction field
    localparam int OPC_LSB = 0;
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;

    typedef enum logic [4:0] {
        OP_NONE,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND,
        OP_SLL, OP_SRL, OP_SRA,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] ins;
        logic [XLEN-1:0] pc;
    } fetch_t;

    // ld marks a value that is still a pending load
    typedef struct packed {
        logic              vld;
        logic              ld;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } fwd_t;

    typedef struct packed {
        logic              vld;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } rf_wb_t;

    typedef struct packed {
        alu_op_e           op;
        logic              wb_vld;
        logic [REG_AW-1:0] wb_addr;
        logic [XLEN-1:0]   src1;
        logic [XLEN-1:0]   src2;
        logic [XLEN-1:0]   br_st_imm;
        logic [XLEN-1:0]   pc;
    } issue_t;

    typedef struct packed {
        alu_op_e op;
        logic    wb_vld;
        logic    use_rs1;
        logic    use_rs2;
        logic    src2_imm;
    } dec_t;

endpackage

`default_nettype wire

//--- hdl/idu_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module idu_op_decode (
    input  logic [idu_pkg::XLEN-1:0] ins_i,
    output idu_pkg::dec_t            dec_o
);
    import idu_pkg::*;

    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       r_fmt, i_fmt, s_fmt, b_fmt, u_fmt, j_fmt;
    alu_op_e    arith_op;
    alu_op_e    op;

    assign opc = ins_i[OPC_LSB +: 7];
    assign f3  = ins_i[F3_LSB +: 3];
    assign f7  = ins_i[F7_LSB +: 7];

    assign r_fmt = (opc == OPC_OP);
    assign i_fmt = (opc == OPC_OP_IMM) | (opc == OPC_LOAD) | (opc == OPC_JALR);
    assign s_fmt = (opc == OPC_STORE);
    assign b_fmt = (opc == OPC_BRANCH);
    assign u_fmt = (opc == OPC_LUI) | (opc == OPC_AUIPC);
    assign j_fmt = (opc == OPC_JAL);

    // base arithmetic op, funct7 qualified below
    always_comb begin
        case (f3)
            F3_ADD:  arith_op = OP_ADD;
            F3_SLL:  arith_op = OP_SLL;
            F3_SLT:  arith_op = OP_SLT;
            F3_SLTU: arith_op = OP_SLTU;
            F3_XOR:  arith_op = OP_XOR;
            F3_SR:   arith_op = OP_SRL;
            F3_OR:   arith_op = OP_OR;
            default: arith_op = OP_AND;
        endcase
    end

    always_comb begin
        op = OP_NONE;
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                if (f7 == F7_ALT && (f3 == F3_SR || (f3 == F3_ADD && r_fmt))) begin
                    op = (f3 == F3_SR) ? OP_SRA : OP_SUB;
                end else if (f7 == F7_NORM || (!r_fmt && f3 != F3_SLL && f3 != F3_SR)) begin
                    // immediate forms carry imm bits in funct7 except for shifts
                    op = arith_op;
                end
            end
            OPC_LOAD: begin
                case (f3)
                    F3_ADD:  op = OP_LB;
                    F3_SLL:  op = OP_LH;
                    F3_SLT:  op = OP_LW;
                    F3_XOR:  op = OP_LBU;
                    F3_SR:   op = OP_LHU;
                    default: op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                case (f3)
                    F3_ADD:  op = OP_SB;
                    F3_SLL:  op = OP_SH;
                    F3_SLT:  op = OP_SW;
                    default: op = OP_NONE;
                endcase
            end
            OPC_BRANCH: begin
                case (f3)
                    F3_ADD:  op = OP_BEQ;
                    F3_SLL:  op = OP_BNE;
                    F3_XOR:  op = OP_BLT;
                    F3_SR:   op = OP_BGE;
                    F3_OR:   op = OP_BLTU;
                    F3_AND:  op = OP_BGEU;
                    default: op = OP_NONE;
                endcase
            end
            OPC_LUI:   op = OP_LUI;
            OPC_AUIPC: op = OP_AUIPC;
            OPC_JAL:   op = OP_JAL;
            OPC_JALR:  op = (f3 == F3_ADD) ? OP_JALR : OP_NONE;
            default:   op = OP_NONE;
        endcase
    end

    assign dec_o = '{
        op:       op,
        wb_vld:   r_fmt | i_fmt | u_fmt | j_fmt,
        use_rs1:  ~(u_fmt | j_fmt),
        use_rs2:  r_fmt | s_fmt | b_fmt,
        src2_imm: i_fmt | u_fmt | j_fmt
    };

endmodule

`default_nettype wire

//--- hdl/idu_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module idu_imm_gen (
    input  logic [idu_pkg::XLEN-1:0] ins_i,
    output logic [idu_pkg::XLEN-1:0] imm_o,
    output logic [idu_pkg::XLEN-1:0] br_st_imm_o
);
    import idu_pkg::*;

    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] u_imm;
    logic [XLEN-1:0] j_imm;

    assign i_imm = {{(XLEN-12){ins_i[31]}}, ins_i[31:20]};
    assign s_imm = {{(XLEN-12){ins_i[31]}}, ins_i[31:25], ins_i[11:7]};
    assign b_imm = {{(XLEN-13){ins_i[31]}}, ins_i[31], ins_i[7], ins_i[30:25],
                    ins_i[11:8], 1'b0};
    // upper 20 bits, zeros below
    assign u_imm = {ins_i[31:12], {(XLEN-20){1'b0}}};
    assign j_imm = {{(XLEN-21){ins_i[31]}}, ins_i[31], ins_i[19:12], ins_i[20],
                    ins_i[30:21], 1'b0};

    always_comb begin
        imm_o       = '0;
        br_st_imm_o = '0;
        case (ins_i[OPC_LSB +: 7])
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: imm_o = i_imm;
            OPC_STORE: begin
                imm_o       = s_imm;
                br_st_imm_o = s_imm;
            end
            OPC_BRANCH: begin
                imm_o       = b_imm;
                br_st_imm_o = b_imm;
            end
            OPC_LUI, OPC_AUIPC: imm_o = u_imm;
            OPC_JAL:            imm_o = j_imm;
            default:            imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/idu_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module idu_bypass (
    input  logic [idu_pkg::REG_AW-1:0] rs_addr_i,
    input  logic                       use_i,
    input  logic [idu_pkg::XLEN-1:0]   rf_data_i,
    input  idu_pkg::fwd_t              alu_fwd_i,
    input  idu_pkg::fwd_t              lsu_fwd_i,
    input  idu_pkg::rf_wb_t            rf_wb_i,
    output logic [idu_pkg::XLEN-1:0]   data_o,
    output logic                       ld_hazard_o
);

    logic alu_hit;
    logic lsu_hit;
    logic rf_hit;

    // x0 is matched like any other register
    assign alu_hit = use_i & alu_fwd_i.vld & (alu_fwd_i.addr == rs_addr_i);
    assign lsu_hit = use_i & lsu_fwd_i.vld & (lsu_fwd_i.addr == rs_addr_i);
    assign rf_hit  = use_i & rf_wb_i.vld & (rf_wb_i.addr == rs_addr_i);

    // pending load result, wait for it
    assign ld_hazard_o = (alu_hit & alu_fwd_i.ld) | (lsu_hit & lsu_fwd_i.ld);

    assign data_o = (alu_hit & ~alu_fwd_i.ld) ? alu_fwd_i.data :
                    (lsu_hit & ~lsu_fwd_i.ld) ? lsu_fwd_i.data :
                    rf_hit                    ? rf_wb_i.data   :
                                                rf_data_i;

endmodule

`default_nettype wire

//--- hdl/idu_issue_reg.sv
`timescale 1ns/1ps
`default_nettype none

module idu_issue_reg (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            ifu_vld_i,
    input  logic            flush_i,
    input  logic            ld_hazard_i,
    input  logic            alu_rdy_i,
    input  idu_pkg::issue_t issue_d_i,
    output logic            ifu_rdy_o,
    output logic            alu_vld_o,
    output idu_pkg::issue_t issue_o
);

    logic            accept;
    logic            vld_q;
    idu_pkg::issue_t issue_q;

    // room when the held item leaves this cycle or none is held
    assign ifu_rdy_o = (alu_rdy_i | ~vld_q) & ~ld_hazard_i;
    assign accept    = ifu_vld_i & ifu_rdy_o & ~flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= accept | (vld_q & ~alu_rdy_i);
        end
    end

    // payload only moves on accept, so it stays put under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_q <= issue_d_i;
        end
    end

    assign alu_vld_o = vld_q;
    assign issue_o   = issue_q;

endmodule

`default_nettype wire

//--- hdl/idu.sv
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       ifu_vld_i,
    input  idu_pkg::fetch_t            fetch_i,
    input  logic                       flush_i,
    input  logic                       alu_rdy_i,
    input  idu_pkg::fwd_t              alu_fwd_i,
    input  idu_pkg::fwd_t              lsu_fwd_i,
    input  idu_pkg::rf_wb_t            rf_wb_i,
    input  logic [idu_pkg::XLEN-1:0]   rf_src1_data_i,
    input  logic [idu_pkg::XLEN-1:0]   rf_src2_data_i,
    output logic                       ifu_rdy_o,
    output logic                       alu_vld_o,
    output idu_pkg::issue_t            issue_o,
    output logic [idu_pkg::REG_AW-1:0] rf_src1_addr_o,
    output logic [idu_pkg::REG_AW-1:0] rf_src2_addr_o
);
    import idu_pkg::*;

    dec_t            dec;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] br_st_imm;
    logic [XLEN-1:0] src1_byp;
    logic [XLEN-1:0] src2_byp;
    logic            src1_ld_hazard;
    logic            src2_ld_hazard;
    issue_t          issue_d;

    // register file read straight from the fetched word
    assign rf_src1_addr_o = fetch_i.ins[RS1_LSB +: REG_AW];
    assign rf_src2_addr_o = fetch_i.ins[RS2_LSB +: REG_AW];

    idu_op_decode i_op_decode (
        .ins_i (fetch_i.ins),
        .dec_o (dec)
    );

    idu_imm_gen i_imm_gen (
        .ins_i       (fetch_i.ins),
        .imm_o       (imm),
        .br_st_imm_o (br_st_imm)
    );

    idu_bypass i_bypass_src1 (
        .rs_addr_i   (rf_src1_addr_o),
        .use_i       (dec.use_rs1),
        .rf_data_i   (rf_src1_data_i),
        .alu_fwd_i   (alu_fwd_i),
        .lsu_fwd_i   (lsu_fwd_i),
        .rf_wb_i     (rf_wb_i),
        .data_o      (src1_byp),
        .ld_hazard_o (src1_ld_hazard)
    );

    idu_bypass i_bypass_src2 (
        .rs_addr_i   (rf_src2_addr_o),
        .use_i       (dec.use_rs2),
        .rf_data_i   (rf_src2_data_i),
        .alu_fwd_i   (alu_fwd_i),
        .lsu_fwd_i   (lsu_fwd_i),
        .rf_wb_i     (rf_wb_i),
        .data_o      (src2_byp),
        .ld_hazard_o (src2_ld_hazard)
    );

    assign issue_d = '{
        op:        dec.op,
        wb_vld:    dec.wb_vld,
        wb_addr:   fetch_i.ins[RD_LSB +: REG_AW],
        src1:      src1_byp,
        src2:      dec.src2_imm ? imm : src2_byp,
        br_st_imm: br_st_imm,
        pc:        fetch_i.pc
    };

    idu_issue_reg i_issue_reg (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ifu_vld_i   (ifu_vld_i),
        .flush_i     (flush_i),
        .ld_hazard_i (src1_ld_hazard | src2_ld_hazard),
        .alu_rdy_i   (alu_rdy_i),
        .issue_d_i   (issue_d),
        .ifu_rdy_o   (ifu_rdy_o),
        .alu_vld_o   (alu_vld_o),
        .issue_o     (issue_o)
    );

endmodule

`default_nettype wire

//--- sim/idu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module idu_asserts (
    input logic            clk,
    input logic            rst_n_i,
    input logic            alu_rdy_i,
    input logic            alu_vld_o,
    input logic            ifu_rdy_o,
    input idu_pkg::issue_t issue_o,
    input idu_pkg::fetch_t fetch_i,
    input idu_pkg::fwd_t   alu_fwd_i,
    input idu_pkg::fwd_t   lsu_fwd_i
);
    import idu_pkg::*;

    logic [6:0]        opc;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic              rs1_used;
    logic              rs2_used;
    logic              rs1_pend;
    logic              rs2_pend;

    assign opc = fetch_i.ins[6:0];
    assign rs1 = fetch_i.ins[19:15];
    assign rs2 = fetch_i.ins[24:20];

    // u and j formats read no rs1, only r, s and b read rs2
    assign rs1_used = (opc != OPC_LUI) && (opc != OPC_AUIPC) && (opc != OPC_JAL);
    assign rs2_used = (opc == OPC_OP) || (opc == OPC_STORE) || (opc == OPC_BRANCH);

    assign rs1_pend = (alu_fwd_i.vld && alu_fwd_i.ld && alu_fwd_i.addr == rs1) ||
                      (lsu_fwd_i.vld && lsu_fwd_i.ld && lsu_fwd_i.addr == rs1);
    assign rs2_pend = (alu_fwd_i.vld && alu_fwd_i.ld && alu_fwd_i.addr == rs2) ||
                      (lsu_fwd_i.vld && lsu_fwd_i.ld && lsu_fwd_i.addr == rs2);

    a_reset_clears_vld: assert property (@(posedge clk) !rst_n_i |=> !alu_vld_o)
        else $error("alu_vld_o high after a reset cycle");

    // held item must not move under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        alu_vld_o && !alu_rdy_i |=> alu_vld_o && $stable(issue_o))
        else $error("issue_o changed while held under back-pressure");

    a_load_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        ((rs1_used && rs1_pend) || (rs2_used && rs2_pend)) |-> !ifu_rdy_o)
        else $error("ifu_rdy_o high with a matching load forward");

endmodule

bind idu idu_asserts i_asserts (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .alu_rdy_i (alu_rdy_i),
    .alu_vld_o (alu_vld_o),
    .ifu_rdy_o (ifu_rdy_o),
    .issue_o   (issue_o),
    .fetch_i   (fetch_i),
    .alu_fwd_i (alu_fwd_i),
    .lsu_fwd_i (lsu_fwd_i)
);

`default_nettype wire

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset held low for four rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/tb_idu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_idu;
    import idu_pkg::*;

    typedef struct packed {
        fetch_t          fetch;
        logic [XLEN-1:0] rf1;
        logic [XLEN-1:0] rf2;
        fwd_t            alu_fwd;
        fwd_t            lsu_fwd;
        rf_wb_t          rf_wb;
        logic            flush;
        issue_t          exp;
    } stim_t;

    logic              clk;
    logic              rst_n;
    logic              ifu_vld_i;
    fetch_t            fetch_i;
    logic              flush_i;
    logic              alu_rdy_i;
    fwd_t              alu_fwd_i;
    fwd_t              lsu_fwd_i;
    rf_wb_t            rf_wb_i;
    logic [XLEN-1:0]   rf_src1_data_i;
    logic [XLEN-1:0]   rf_src2_data_i;
    logic              ifu_rdy_o;
    logic              alu_vld_o;
    issue_t            issue_o;
    logic [REG_AW-1:0] rf_src1_addr_o;
    logic [REG_AW-1:0] rf_src2_addr_o;

    stim_t  stims [0:63];
    int     n_lines = 0;
    issue_t exp_q [$];
    int     mismatch_cnt = 0;
    int     error_cnt = 0;
    int     cycles = 0;
    int     limit = 0;
    integer seed = 50050;

    tb_clk_gen i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    idu i_dut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .ifu_vld_i      (ifu_vld_i),
        .fetch_i        (fetch_i),
        .flush_i        (flush_i),
        .alu_rdy_i      (alu_rdy_i),
        .alu_fwd_i      (alu_fwd_i),
        .lsu_fwd_i      (lsu_fwd_i),
        .rf_wb_i        (rf_wb_i),
        .rf_src1_data_i (rf_src1_data_i),
        .rf_src2_data_i (rf_src2_data_i),
        .ifu_rdy_o      (ifu_rdy_o),
        .alu_vld_o      (alu_vld_o),
        .issue_o        (issue_o),
        .rf_src1_addr_o (rf_src1_addr_o),
        .rf_src2_addr_o (rf_src2_addr_o)
    );

    task automatic load_stim();
        int          fd;
        int          cnt;
        string       line;
        stim_t       s;
        logic [31:0] f [0:20];
        fd = $fopen("sim/idu_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file sim/idu_stim.txt");
            error_cnt++;
            return;
        end
        while (!$feof(fd) && n_lines < 64) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                              f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                              f[18], f[19], f[20]);
                if (cnt == 21) begin
                    s.fetch.ins     = f[0];
                    s.fetch.pc      = f[1];
                    s.rf1           = f[2];
                    s.rf2           = f[3];
                    s.alu_fwd       = {f[4][0], f[5][0], f[6][4:0], f[7]};
                    s.lsu_fwd       = {f[8][0], f[9][0], f[10][4:0], f[11]};
                    s.rf_wb         = {f[12][0], f[13][4:0], f[14]};
                    s.flush         = f[15][0];
                    s.exp.op        = alu_op_e'(f[16][4:0]);
                    s.exp.wb_vld    = f[17][0];
                    // rd field of the instruction
                    s.exp.wb_addr   = f[0][11:7];
                    s.exp.src1      = f[18];
                    s.exp.src2      = f[19];
                    s.exp.br_st_imm = f[20];
                    s.exp.pc        = f[1];
                    stims[n_lines]  = s;
                    n_lines++;
                end else begin
                    $display("malformed stimulus line: %s", line);
                    error_cnt++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic apply(input stim_t s);
        ifu_vld_i      = 1'b1;
        fetch_i        = s.fetch;
        flush_i        = s.flush;
        alu_fwd_i      = s.alu_fwd;
        lsu_fwd_i      = s.lsu_fwd;
        rf_wb_i        = s.rf_wb;
        rf_src1_data_i = s.rf1;
        rf_src2_data_i = s.rf2;
    endtask

    task automatic present(input int idx);
        stim_t s;
        s = stims[idx];
        @(posedge clk);
        #1;
        apply(s);
        if (s.flush) begin
            // three edges with flush high, nothing may be accepted
            repeat (3) @(negedge clk);
        end else begin
            if (s.alu_fwd.ld || s.lsu_fwd.ld) begin
                repeat (3) begin
                    @(negedge clk);
                    if (ifu_rdy_o) begin
                        $display("ifu_rdy_o high at %0t with a load forward pending, pc %h",
                                 $time, s.fetch.pc);
                        error_cnt++;
                    end
                    @(posedge clk);
                    #1;
                end
                // load data has arrived, drop the pending forward
                if (s.alu_fwd.ld) s.alu_fwd.vld = 1'b0;
                if (s.lsu_fwd.ld) s.lsu_fwd.vld = 1'b0;
                apply(s);
            end
            @(negedge clk);
            while (!ifu_rdy_o) begin
                @(posedge clk);
                @(negedge clk);
            end
            exp_q.push_back(s.exp);
        end
    endtask

    task automatic check_issue();
        issue_t e;
        if (exp_q.size() == 0) begin
            $display("unexpected issue at %0t with pc %h, no instruction was pending",
                     $time, issue_o.pc);
            error_cnt++;
            return;
        end
        e = exp_q.pop_front();
        if (issue_o.op !== e.op || issue_o.wb_vld !== e.wb_vld ||
            issue_o.wb_addr !== e.wb_addr || issue_o.src1 !== e.src1 ||
            issue_o.src2 !== e.src2 || issue_o.br_st_imm !== e.br_st_imm ||
            issue_o.pc !== e.pc) begin
            $display("mismatch at %0t: pc %h op %0d wb %b rd %0d src1 %h src2 %h imm %h",
                     $time, issue_o.pc, issue_o.op, issue_o.wb_vld, issue_o.wb_addr,
                     issue_o.src1, issue_o.src2, issue_o.br_st_imm);
            $display("  expected pc %h op %0d wb %b rd %0d src1 %h src2 %h imm %h",
                     e.pc, e.op, e.wb_vld, e.wb_addr, e.src1, e.src2, e.br_st_imm);
            mismatch_cnt++;
        end
    endtask

    task automatic check_rf_addr();
        logic [REG_AW-1:0] exp_rs1;
        logic [REG_AW-1:0] exp_rs2;
        // rs1 and rs2 fields of the presented word
        exp_rs1 = fetch_i.ins[19:15];
        exp_rs2 = fetch_i.ins[24:20];
        if (rf_src1_addr_o !== exp_rs1 || rf_src2_addr_o !== exp_rs2) begin
            $display("mismatch at %0t: rf read addr %0d %0d, expected %0d %0d",
                     $time, rf_src1_addr_o, rf_src2_addr_o, exp_rs1, exp_rs2);
            mismatch_cnt++;
        end
    endtask

    // issue happens on the next rising edge
    always @(negedge clk) begin
        if (rst_n && alu_vld_o && alu_rdy_i) begin
            check_issue();
        end
    end

    always @(negedge clk) begin
        if (rst_n && ifu_vld_i) begin
            check_rf_addr();
        end
    end

    always @(posedge clk) begin
        #1;
        alu_rdy_i = (($random(seed) & 3) != 0);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, issue queue still holds %0d entries",
                     cycles, exp_q.size());
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        ifu_vld_i      = 1'b0;
        fetch_i        = '0;
        flush_i        = 1'b0;
        alu_rdy_i      = 1'b0;
        alu_fwd_i      = '0;
        lsu_fwd_i      = '0;
        rf_wb_i        = '0;
        rf_src1_data_i = '0;
        rf_src2_data_i = '0;
        load_stim();
        limit = 40 * n_lines;
        @(posedge rst_n);
        for (int i = 0; i < n_lines; i++) begin
            present(i);
        end
        @(posedge clk);
        #1;
        ifu_vld_i = 1'b0;
        flush_i   = 1'b0;
        @(negedge clk);
        while (exp_q.size() != 0 || alu_vld_o) begin
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, error_cnt);
        if (mismatch_cnt == 0 && error_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- idu.f
hdl/idu_pkg.sv
hdl/idu_op_decode.sv
hdl/idu_imm_gen.sv
hdl/idu_bypass.sv
hdl/idu_issue_reg.sv
hdl/idu.sv
sim/idu_asserts.sv
sim/tb_clk_gen.sv
sim/tb_idu.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f idu.f --top-module tb_idu \
    --Mdir obj_dir -o tb_idu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_idu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- sim/idu_stim.txt
# ins pc rf1 rf2, alu fwd vld ld addr data, lsu fwd vld ld addr data, rf wb vld addr data, flush
# expected op wb_vld src1 src2 br_st_imm, all fields hex
002081B3 00000100 11111111 22222222 0 0 00 00000000 0 0 00 00000000 0 00 00000000 0 01 1 11111111 22222222 00000000
402082B3 00000104 11111111 22222222 1 0 01 AAAA0001 1 0 01 BBBB0001 1 02 CCCC0002 0 02 1 AAAA0001 CCCC0002 00000000
0020C333 00000108 11111111 22222222 1 0 02 AAAA0002 1 0 01 BBBB0001 1 01 CCCC0001 0 05 1 BBBB0001 AAAA0002 00000000
FFF08393 0000010C 11111111 22222222 0 0 00 00000000 0 0 00 00000000 0 00 00000000 0 01 1 11111111 FFFFFFFF 00000000
4030D413 00000110 11111111 22222222 0 0 00 00000000 0 0 00 00000000 0 00 00000000 0 0a 1 11111111 00000403 00000000
0080A483 00000114 11111111 22222222 0 0 00 00000000 0 0 00 00000000 0 00 00000000 0 13 1 11111111 00000008 00000000
0020A623 00000118 11111111 22222222 0 0 00 00000000 0 0 00 00000000 0 00 00000000 0 18 0 11111111 22222222 0000000C
FE208CE3 0000011C 11111111 22222222 0 0 00 00000000 0 0 00 00000000 0 00 00000000 0 0b 0 11111111 22222222 FFFFFFF8
12345537 00000120 11111111 22222222 1 0 08 AAAA0008 0 0 00 00000000 0 00 00000000 0 19 1 11111111 12345000 00000000
FFFFF597 00000124 11111111 22222222 0 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1a 1 11111111 FFFFF000 00000000
010000EF 00000128 11111111 22222222 0 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1b 1 11111111 00000010 00000000
00408067 0000012C 11111111 22222222 0 0 00 00000000 0 0 00 00000000 1 01 CCCC0001 0 1c 1 CCCC0001 00000004 00000000
002081B3 00000130 11111111 22222222 0 0 00 00000000 1 1 02 BBBB0002 0 00 00000000 0 01 1 11111111 22222222 00000000
00208233 00000134 11111111 22222222 0 0 00 00000000 0 0 00 00000000 0 00 00000000 1 00 0 00000000 00000000 00000000
0020E633 00000138 11111111 22222222 0 0 00 00000000 0 0 00 00000000 0 00 00000000 0 06 1 11111111 22222222 00000000
40109093 0000013C 11111111 22222222 0 0 00 00000000 0 0 00 00000000 0 00 00000000 0 00 1 11111111 00000401 00000000
